/* flist.f */
hdl/cache_pkg.sv
hdl/wb_pkg.sv
hdl/line_store_if.sv
hdl/req_fifo.sv
hdl/lru_tracker.sv
hdl/line_store.sv
hdl/cache_ctrl.sv
hdl/ddr3_cache.sv
test/ddr3_mem_model.sv
test/tb_ddr3_cache.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_ddr3_cache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# a failing run ends in $fatal, which gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_ddr3_cache.sv */
`timescale 1ns/10ps

module tb_ddr3_cache import cache_pkg::*, wb_pkg::*; ();

  // about 120 requests of up to 40 cycles at 4 ns
  localparam int WATCHDOG_NS = 20000;

  logic  clk;
  logic  rst;
  adr_t  bus_adr;
  word_t bus_wdata;
  logic  bus_we;
  sel_t  bus_sel;
  logic  bus_stb;
  logic  bus_cyc;
  logic  bus_ack;
  logic  bus_stall;
  word_t bus_rdata;
  adr_t  dst_adr;
  line_t dst_wdata;
  line_t dst_rdata;
  logic  dst_we;
  logic  dst_stb;
  logic  dst_cyc;
  logic  dst_ack;
  logic  dst_stall;
  logic  stall_en;

  logic [7:0]  ref_mem [adr_t];
  bit          dirty_lines [adr_t];
  adr_t        lru_q[$];       // front is the most recently used line
  adr_t        wb_adr_q[$];
  line_t       wb_line_q[$];
  logic        exp_we_q[$];
  word_t       exp_data_q[$];
  int          issued;
  int          acks_seen;
  int          wb_count;
  int          dst_busy;
  int          edge_count;
  int          accept_edge;
  int          last_ack_edge;
  adr_t        last_wb_adr;
  logic [15:0] lfsr;

  ddr3_cache ddr3_cache_i (
    .clk (clk), .rst (rst),
    .bus_adr_i (bus_adr), .bus_data_i (bus_wdata), .bus_we_i (bus_we), .bus_sel_i (bus_sel),
    .bus_stb_i (bus_stb), .bus_cyc_i (bus_cyc), .bus_ack_o (bus_ack),
    .bus_stall_o (bus_stall), .bus_data_o (bus_rdata),
    .dst_adr_o (dst_adr), .dst_data_o (dst_wdata), .dst_we_o (dst_we), .dst_stb_o (dst_stb),
    .dst_cyc_o (dst_cyc), .dst_ack_i (dst_ack), .dst_stall_i (dst_stall), .dst_data_i (dst_rdata)
  );

  ddr3_mem_model mem_i (
    .clk (clk), .rst (rst), .stall_en_i (stall_en), .cyc_i (dst_cyc), .stb_i (dst_stb),
    .we_i (dst_we), .adr_i (dst_adr), .data_i (dst_wdata), .stall_o (dst_stall),
    .ack_o (dst_ack), .data_o (dst_rdata)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    edge_count++;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp));
  endtask

  task automatic check_line(input line_t got, input line_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("error at %0t ns: %s is 0x%032h, expected 0x%032h", $time, what, got, exp));
  endtask

  task automatic check_adr(input adr_t got, input adr_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp));
  endtask

  function automatic logic [7:0] ref_byte(input adr_t a);
    word_t w;
    if (ref_mem.exists(a))
      return ref_mem[a];
    w = {a[31:2], 2'b00} ^ 32'hA5A50000;
    return w[a[1:0]*8 +: 8];
  endfunction

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = next_lfsr(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // models the cache contents at issue time, which is enough since requests finish in order
  task automatic predict(input adr_t adr, input word_t data, input logic we, input sel_t sel);
    adr_t  la;
    adr_t  wa;
    adr_t  victim;
    int    pos;
    line_t wb_line;
    word_t rd;
    la  = {adr[31:4], 4'h0};
    wa  = {adr[31:2], 2'b00};
    pos = -1;
    foreach (lru_q[k])
      if (lru_q[k] == la)
        pos = k;
    if (pos >= 0)
      lru_q.delete(pos);
    else if (lru_q.size() == LINE_COUNT)
    begin
      victim = lru_q.pop_back();
      if (dirty_lines.exists(victim))
      begin
        for (int k = 0; k < LINE_BYTES; k++)
          wb_line[k*8 +: 8] = ref_byte(victim + adr_t'(k));
        wb_adr_q.push_back(victim);
        wb_line_q.push_back(wb_line);
        dirty_lines.delete(victim);
      end
    end
    lru_q.push_front(la);
    for (int b = 0; b < SEL_W; b++)
    begin
      if (we && sel[b])
        ref_mem[wa + adr_t'(b)] = data[b*8 +: 8];
      rd[b*8 +: 8] = sel[b] ? ref_byte(wa + adr_t'(b)) : 8'h00;
    end
    if (we)
      dirty_lines[la] = 1'b1;
    exp_we_q.push_back(we);
    exp_data_q.push_back(rd);
  endtask

  // the request is held until a cycle without stall
  task automatic issue(input adr_t adr, input word_t data, input logic we, input sel_t sel);
    @(posedge clk);
    #1;
    bus_adr   = adr;
    bus_wdata = data;
    bus_we    = we;
    bus_sel   = sel;
    bus_cyc   = 1'b1;
    bus_stb   = 1'b1;
    @(negedge clk);
    while (bus_stall)
      @(negedge clk);
    accept_edge = edge_count + 1;
    predict(adr, data, we, sel);
    issued++;
  endtask

  task automatic idle_bus();
    @(posedge clk);
    #1;
    bus_stb = 1'b0;
    bus_cyc = 1'b0;
    bus_we  = 1'b0;
    bus_sel = '0;
  endtask

  task automatic wait_acks();
    int cycles;
    cycles = 0;
    while (acks_seen != issued)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > 2000)
        fail_now("the cache did not acknowledge all requests within 2000 cycles");
    end
    if (wb_adr_q.size() != 0)
      fail_now("an expected write-back never appeared on the memory port");
  endtask

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (dst_cyc)
        dst_busy++;
      if (bus_ack)
      begin
        if (exp_we_q.size() == 0)
          fail_now("the cache acknowledged a request that was never accepted");
        if (!exp_we_q.pop_front())
          check_word(bus_rdata, exp_data_q[0], "read data");
        void'(exp_data_q.pop_front());
        acks_seen++;
        last_ack_edge = edge_count + 1;  // the edge where the master samples ack
      end
      if (dst_cyc && dst_stb && dst_we && !dst_stall)
      begin
        if (wb_adr_q.size() == 0)
          fail_now("the cache wrote back a line that was not expected to be dirty");
        check_adr(dst_adr, wb_adr_q.pop_front(), "write-back address");
        check_line(dst_wdata, wb_line_q.pop_front(), "write-back data");
        last_wb_adr = dst_adr;
        wb_count++;
      end
    end
  end

  task automatic reset_outputs_test();
    check_word(word_t'({bus_ack, bus_stall, dst_cyc, dst_stb, dst_we}), '0,
               "control outputs after reset");
  endtask

  task automatic read_hit_test();
    int busy_before;
    issue(32'h0000_1008, '0, 1'b0, 4'hf);  // miss, loads the line
    idle_bus();
    wait_acks();
    busy_before = dst_busy;
    issue(32'h0000_1004, '0, 1'b0, 4'hf);
    idle_bus();
    wait_acks();
    check_word(word_t'(last_ack_edge - accept_edge), 32'd3, "hit ack latency in cycles");
    check_word(word_t'(dst_busy - busy_before), '0, "memory port cycles during a hit");
  endtask

  task automatic merge_test();
    issue(32'h0000_1004, 32'h1122_3344, 1'b1, 4'b0101);
    issue(32'h0000_1004, '0, 1'b0, 4'hf);
    issue(32'h0000_1004, '0, 1'b0, 4'b0010);
    issue(32'h0000_2000, '0, 1'b0, 4'b1000);
    idle_bus();
    wait_acks();
  endtask

  task automatic lru_test();
    adr_t base;
    int   wb_before;
    base = 32'h0020_0000;
    for (int i = 0; i < LINE_COUNT; i++)
      issue(base + adr_t'(i * 16 + (i % 4) * 4), 32'hC0DE_0000 | word_t'(i), 1'b1, 4'hf);
    issue(base, '0, 1'b0, 4'hf);  // touch the first line
    idle_bus();
    wait_acks();
    wb_before = wb_count;
    issue(base + adr_t'(LINE_COUNT * 16), 32'h0BAD_F00D, 1'b1, 4'hf);
    idle_bus();
    wait_acks();
    check_word(word_t'(wb_count - wb_before), 32'd1, "write-backs for the 33rd line");
    check_adr(last_wb_adr, base + adr_t'(16), "first victim after the touch");
  endtask

  task automatic random_burst_test();
    logic [31:0] r;
    adr_t        adr;
    sel_t        sel;
    logic        we;
    #1 stall_en = 1'b1;
    for (int n = 0; n < 60; n++)
    begin
      draw_bits(6, r);
      adr = 32'h0030_0000 + adr_t'(r[5:0]) * 16;
      draw_bits(2, r);
      adr = adr + adr_t'(r[1:0]) * 4;
      draw_bits(1, r);
      we = r[0];
      draw_bits(4, r);
      sel = (r[3:0] == 4'h0) ? 4'hf : r[3:0];
      draw_bits(32, r);
      issue(adr, r, we, sel);
    end
    idle_bus();
    wait_acks();
    stall_en = 1'b0;
  endtask

  initial
  begin
    #WATCHDOG_NS;
    fail_now("the simulation ran past its time limit and was stopped");
  end

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    bus_adr    = '0;
    bus_wdata  = '0;
    bus_we     = 1'b0;
    bus_sel    = '0;
    bus_stb    = 1'b0;
    bus_cyc    = 1'b0;
    stall_en   = 1'b0;
    issued     = 0;
    acks_seen  = 0;
    wb_count   = 0;
    dst_busy   = 0;
    edge_count = 0;
    lfsr       = 16'd34870;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    reset_outputs_test();
    read_hit_test();
    merge_test();
    lru_test();
    random_burst_test();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* test/ddr3_mem_model.sv */
`timescale 1ns/10ps

module ddr3_mem_model import cache_pkg::*, wb_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  stall_en_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  adr_t  adr_i,
  input  line_t data_i,
  output logic  stall_o,
  output logic  ack_o,
  output line_t data_o
);

  line_t       mem [adr_t];  // only lines that were written back
  logic [15:0] lfsr;
  logic [15:0] lfsr_next;
  logic [1:0]  wait_cnt;
  adr_t        rd_adr;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic line_t read_line(input adr_t a);
    line_t l;
    if (mem.exists(a))
      return mem[a];
    for (int w = 0; w < 4; w++)
      l[w*32 +: 32] = (a + adr_t'(4 * w)) ^ 32'hA5A50000;
    return l;
  endfunction

  assign lfsr_next = next_lfsr(lfsr);

  initial
  begin
    stall_o = 1'b0;
    ack_o   = 1'b0;
    data_o  = '0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      stall_o  <= 1'b0;
      ack_o    <= 1'b0;
      wait_cnt <= '0;
      lfsr     <= 16'd34870;
    end
    else
    begin
      ack_o <= 1'b0;
      if (stall_en_i)
      begin
        lfsr    <= lfsr_next;
        stall_o <= lfsr_next[0];  // one new bit per cycle
      end
      else
        stall_o <= 1'b0;
      if (cyc_i && stb_i && !stall_o)
      begin
        if (we_i)
          mem[adr_i] = data_i;
        else
        begin
          rd_adr   <= adr_i;
          wait_cnt <= 2'd3;
        end
      end
      else if (wait_cnt != 2'd0)
      begin
        wait_cnt <= wait_cnt - 2'd1;
        if (wait_cnt == 2'd1)
        begin
          ack_o  <= 1'b1;
          data_o <= read_line(rd_adr);
        end
      end
    end
  end

endmodule

/* hdl/ddr3_cache.sv */
`timescale 1ns/10ps

module ddr3_cache import cache_pkg::*, wb_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  input  adr_t  bus_adr_i,
  input  word_t bus_data_i,
  input  logic  bus_we_i,
  input  sel_t  bus_sel_i,
  input  logic  bus_stb_i,
  input  logic  bus_cyc_i,
  output logic  bus_ack_o,
  output logic  bus_stall_o,
  output word_t bus_data_o,

  output adr_t  dst_adr_o,
  output line_t dst_data_o,
  output logic  dst_we_o,
  output logic  dst_stb_o,
  output logic  dst_cyc_o,
  input  logic  dst_ack_i,
  input  logic  dst_stall_i,
  input  line_t dst_data_i
);

  bus_req_t  bus_req;
  bus_req_t  head;
  logic      push;
  logic      empty;
  logic      pop;
  logic      lru_touch;
  line_idx_t lru_idx;
  line_idx_t lru;

  line_store_if store_if ();

  // a pipelined master may present a new request every cycle unless stalled
  assign push    = bus_cyc_i & bus_stb_i & ~bus_stall_o;
  assign bus_req = '{adr: bus_adr_i, data: bus_data_i, we: bus_we_i, sel: bus_sel_i};

  req_fifo req_fifo_i (
    .clk     (clk),
    .rst     (rst),
    .push_i  (push),
    .req_i   (bus_req),
    .pop_i   (pop),
    .head_o  (head),
    .empty_o (empty),
    .stall_o (bus_stall_o)
  );

  cache_ctrl cache_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .head_i      (head),
    .empty_i     (empty),
    .pop_o       (pop),
    .lru_touch_o (lru_touch),
    .lru_idx_o   (lru_idx),
    .store       (store_if.ctrl),
    .bus_ack_o   (bus_ack_o),
    .bus_data_o  (bus_data_o),
    .dst_adr_o   (dst_adr_o),
    .dst_data_o  (dst_data_o),
    .dst_we_o    (dst_we_o),
    .dst_stb_o   (dst_stb_o),
    .dst_cyc_o   (dst_cyc_o),
    .dst_ack_i   (dst_ack_i),
    .dst_stall_i (dst_stall_i),
    .dst_data_i  (dst_data_i)
  );

  line_store line_store_i (
    .clk   (clk),
    .rst   (rst),
    .lru_i (lru),
    .ls    (store_if.store)
  );

  lru_tracker lru_tracker_i (
    .clk         (clk),
    .rst         (rst),
    .lru_touch_i (lru_touch),
    .lru_idx_i   (lru_idx),
    .lru_o       (lru)
  );

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*, wb_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  bus_req_t   head_i,
  input  logic       empty_i,
  output logic       pop_o,

  output logic       lru_touch_o,
  output line_idx_t  lru_idx_o,

  line_store_if.ctrl store,

  output logic       bus_ack_o,
  output word_t      bus_data_o,

  output adr_t       dst_adr_o,
  output line_t      dst_data_o,
  output logic       dst_we_o,
  output logic       dst_stb_o,
  output logic       dst_cyc_o,
  input  logic       dst_ack_i,
  input  logic       dst_stall_i,
  input  line_t      dst_data_i
);

  ctrl_state_t state;
  line_idx_t   idx_q;         // line chosen for the request at the head
  tag_t        victim_tag_q;
  tag_t        head_tag;
  logic [1:0]  word_sel;
  word_t       cur_word;
  word_t       rd_word;
  line_t       merged_line;

  assign head_tag = head_i.adr[TAG_MSB:TAG_LSB];
  assign word_sel = head_i.adr[3:2];

  assign store.lookup_tag = head_tag;
  assign store.sel_idx    = idx_q;
  assign store.fill_tag   = head_tag;
  assign store.fill_data  = dst_data_i;
  assign store.wr_line    = merged_line;
  assign store.invalidate = (state == st_flush) && !dst_stall_i;
  assign store.fill       = (state == st_load_wait) && dst_ack_i;
  assign store.set_dirty  = (state == st_update) && head_i.we;

  assign pop_o       = (state == st_update);
  assign lru_touch_o = (state == st_update);
  assign lru_idx_o   = idx_q;

  // requests on the memory side follow the state directly so they stay stable under stall
  assign dst_cyc_o  = state inside {st_flush, st_load, st_load_wait};
  assign dst_stb_o  = state inside {st_flush, st_load};
  assign dst_we_o   = (state == st_flush);
  assign dst_data_o = store.rd_line;
  assign dst_adr_o  = (state == st_flush) ?
                      {{(ADR_W-TAG_MSB-1){1'b0}}, victim_tag_q, {TAG_LSB{1'b0}}} :
                      {{(ADR_W-TAG_MSB-1){1'b0}}, head_tag, {TAG_LSB{1'b0}}};

  always_comb
  begin
    cur_word    = store.rd_line[word_sel*DAT_W +: DAT_W];
    merged_line = store.rd_line;
    for (int b = 0; b < SEL_W; b++)
    begin
      if (head_i.sel[b])
        merged_line[word_sel*DAT_W + b*8 +: 8] = head_i.data[b*8 +: 8];
      rd_word[b*8 +: 8] = head_i.sel[b] ? cur_word[b*8 +: 8] : 8'h00;  // unselected lanes read zero
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= st_idle;
      bus_ack_o <= 1'b0;
    end
    else
    begin
      bus_ack_o <= 1'b0;
      case (state)
        st_idle:
        begin
          if (!empty_i)
          begin
            if (store.hit)
              state <= st_update;
            else if (store.victim_dirty)
              state <= st_flush;
            else
              state <= st_load;
          end
        end
        st_flush:
        begin
          if (!dst_stall_i)
            state <= st_load;  // the write-back needs no ack
        end
        st_load:
        begin
          if (!dst_stall_i)
            state <= st_load_wait;
        end
        st_load_wait:
        begin
          if (dst_ack_i)
            state <= st_update;
        end
        st_update:
        begin
          bus_ack_o <= 1'b1;
          state     <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_idle)
    begin
      idx_q        <= store.hit ? store.hit_idx : store.victim_idx;
      victim_tag_q <= store.victim_tag;
    end
    if (state == st_update)
      bus_data_o <= rd_word;
  end

  assert property (@(posedge clk) disable iff (rst) bus_ack_o |=> !bus_ack_o)
    else $error("bus ack held for two cycles");

endmodule

/* hdl/line_store.sv */
`timescale 1ns/10ps

module line_store import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  line_idx_t   lru_i,
  line_store_if.store ls
);

  logic [LINE_COUNT-1:0] valid;
  logic [LINE_COUNT-1:0] dirty;
  tag_t                  tags [LINE_COUNT];
  line_t                 data [LINE_COUNT];
  logic                  any_free;
  line_idx_t             free_idx;

  // fully associative so every valid tag is compared
  always_comb
  begin
    ls.hit     = 1'b0;
    ls.hit_idx = '0;
    for (int i = 0; i < LINE_COUNT; i++)
    begin
      if (valid[i] && tags[i] == ls.lookup_tag)
      begin
        ls.hit     = 1'b1;
        ls.hit_idx = line_idx_t'(i);
      end
    end
  end

  always_comb
  begin
    any_free = 1'b0;
    free_idx = '0;
    for (int i = LINE_COUNT - 1; i >= 0; i--)  // downward scan leaves the lowest one
    begin
      if (!valid[i])
      begin
        any_free = 1'b1;
        free_idx = line_idx_t'(i);
      end
    end
  end

  assign ls.victim_idx   = any_free ? free_idx : lru_i;
  assign ls.victim_dirty = valid[ls.victim_idx] & dirty[ls.victim_idx];
  assign ls.victim_tag   = tags[ls.victim_idx];
  assign ls.rd_line      = data[ls.sel_idx];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else
    begin
      if (ls.invalidate)
      begin
        valid[ls.sel_idx] <= 1'b0;
        dirty[ls.sel_idx] <= 1'b0;
      end
      if (ls.fill)
      begin
        valid[ls.sel_idx] <= 1'b1;
        dirty[ls.sel_idx] <= 1'b0;
      end
      if (ls.set_dirty)
        dirty[ls.sel_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ls.fill)
    begin
      tags[ls.sel_idx] <= ls.fill_tag;
      data[ls.sel_idx] <= ls.fill_data;
    end
    if (ls.set_dirty)
      data[ls.sel_idx] <= ls.wr_line;  // merged write from the update step
  end

endmodule

/* hdl/lru_tracker.sv */
`timescale 1ns/10ps

module lru_tracker import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      lru_touch_i,
  input  line_idx_t lru_idx_i,
  output line_idx_t lru_o
);

  line_idx_t             rank [LINE_COUNT];  // 0 is the most recently used
  line_idx_t             touched_rank;
  logic [LINE_COUNT-1:0] rank_seen;

  assign touched_rank = rank[lru_idx_i];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < LINE_COUNT; i++)
        rank[i] <= line_idx_t'(i);
    end
    else if (lru_touch_i)
    begin
      for (int i = 0; i < LINE_COUNT; i++)
      begin
        if (line_idx_t'(i) == lru_idx_i)
          rank[i] <= '0;
        else if (rank[i] < touched_rank)
          rank[i] <= rank[i] + 1'b1;  // lines older than the touched one keep their rank
      end
    end
  end

  always_comb
  begin
    lru_o = '0;
    for (int i = 0; i < LINE_COUNT; i++)
      if (rank[i] == line_idx_t'(LINE_COUNT - 1))
        lru_o = line_idx_t'(i);
  end

  always_comb
  begin
    rank_seen = '0;
    for (int i = 0; i < LINE_COUNT; i++)
      rank_seen[rank[i]] = 1'b1;
  end

  assert property (@(posedge clk) disable iff (rst) lru_touch_i |=> &rank_seen)
    else $error("lru ranks are no longer a permutation");

endmodule

/* hdl/req_fifo.sv */
`timescale 1ns/10ps

module req_fifo import wb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_i,
  input  bus_req_t req_i,
  input  logic     pop_i,
  output bus_req_t head_o,
  output logic     empty_o,
  output logic     stall_o
);

  bus_req_t                        buffer [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;

  assign head_o  = buffer[rd_ptr];
  assign empty_o = (count == '0);
  // one slot of slack covers the request already on the bus when stall rises
  assign stall_o = (count >= FIFO_DEPTH - 1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so the pointers wrap
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_i)
      buffer[wr_ptr] <= req_i;
  end

  // push is gated by the top level and pop comes from the controller
  assert property (@(posedge clk) disable iff (rst) push_i |-> count < FIFO_DEPTH)
    else $error("request pushed into a full queue");

  assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o)
    else $error("request popped from an empty queue");

endmodule

/* hdl/line_store_if.sv */
`timescale 1ns/10ps

interface line_store_if import cache_pkg::*; ();

  // lookup results, all combinational from the arrays
  logic      hit;
  line_idx_t hit_idx;
  line_idx_t victim_idx;
  logic      victim_dirty;
  tag_t      victim_tag;
  line_t     rd_line;   // line at sel_idx

  tag_t      lookup_tag;
  line_idx_t sel_idx;
  logic      invalidate;
  logic      fill;
  tag_t      fill_tag;
  line_t     fill_data;
  line_t     wr_line;
  logic      set_dirty;  // also writes wr_line into the selected line

  modport ctrl (
    input  hit, hit_idx, victim_idx, victim_dirty, victim_tag, rd_line,
    output lookup_tag, sel_idx, invalidate, fill, fill_tag, fill_data, wr_line, set_dirty
  );

  modport store (
    output hit, hit_idx, victim_idx, victim_dirty, victim_tag, rd_line,
    input  lookup_tag, sel_idx, invalidate, fill, fill_tag, fill_data, wr_line, set_dirty
  );

endinterface

/* hdl/wb_pkg.sv */
package wb_pkg;

  // pipelined wishbone slave port
  localparam int ADR_W = 32;
  localparam int DAT_W = 32;
  localparam int SEL_W = DAT_W / 8;

  localparam int FIFO_DEPTH = 4;

  typedef logic [ADR_W-1:0] adr_t;

  typedef logic [DAT_W-1:0] word_t;

  typedef logic [SEL_W-1:0] sel_t;

  // one accepted bus cycle as it waits in the request queue
  typedef struct packed {
    adr_t  adr;
    word_t data;
    logic  we;
    sel_t  sel;
  } bus_req_t;

endpackage

/* hdl/cache_pkg.sv */
package cache_pkg;

  // geometry of the line array
  localparam int LINE_COUNT = 32;
  localparam int LINE_BYTES = 16;  // one beat of the ddr3 controller port

  // the tag covers the address bits above the line offset
  localparam int TAG_LSB = 4;
  localparam int TAG_MSB = 25;

  typedef logic [$clog2(LINE_COUNT)-1:0] line_idx_t;

  typedef logic [TAG_MSB-TAG_LSB:0] tag_t;

  typedef logic [LINE_BYTES*8-1:0] line_t;

  // controller steps for one queued request
  typedef enum logic [2:0] {
    st_idle,
    st_flush,      // writing a dirty victim back
    st_load,       // read request held until the memory takes it
    st_load_wait,
    st_update
  } ctrl_state_t;

endpackage
